// File: Makefile
# Verilator build and run of the dispatch stage testbench
SRCS = hdl/disp_pkg.sv hdl/credit_counter.sv hdl/brtag_alloc.sv \
       hdl/resource_alloc.sv hdl/disp_group_buf.sv hdl/disp_out_stage.sv \
       hdl/disp_top.sv verification/disp_asserts.sv verification/disp_tb.sv

obj_dir/Vdisp_tb: build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module disp_tb -f build.f

.PHONY: run clean

run: obj_dir/Vdisp_tb
	./obj_dir/Vdisp_tb

clean:
	rm -rf obj_dir

// File: build.f
hdl/disp_pkg.sv
hdl/credit_counter.sv
hdl/brtag_alloc.sv
hdl/resource_alloc.sv
hdl/disp_group_buf.sv
hdl/disp_out_stage.sv
hdl/disp_top.sv
verification/disp_asserts.sv
verification/disp_tb.sv

// File: hdl/brtag_alloc.sv
// --------------------------------------------------
// branch tag allocation for one dispatch group
// tags are handed out round robin from the pointer
// the pointer is not rolled back on a mispredict
// --------------------------------------------------

module brtag_alloc (
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  input  disp_pkg::disp_group_t   i_group,
  input  logic                    i_alloc,

  input  disp_pkg::br_upd_t       i_br_upd,
  input  logic                    i_commit_flush,

  output logic                    o_tag_ok,
  output disp_pkg::tagged_group_t o_group
);

  disp_pkg::brtag_t  r_tag_ptr;
  disp_pkg::brmask_t r_mask_valid;
  disp_pkg::brmask_t w_mask_next;

  disp_pkg::brcnt_t  w_free_cnt;
  disp_pkg::brcnt_t  w_br_cnt;

  disp_pkg::brtag_t  w_tag_chain  [disp_pkg::DISP_SIZE+1];
  disp_pkg::brmask_t w_mask_chain [disp_pkg::DISP_SIZE+1];
  logic              w_is_br      [disp_pkg::DISP_SIZE];

  // --------------------------------------------------
  // release of resolved and squashed branches
  // --------------------------------------------------
  always_comb begin
    w_mask_next = r_mask_valid;
    w_free_cnt  = '0;
    for (int b = 0; b < disp_pkg::BR_TAG_NUM; b++) begin
      // own tag resolved
      if (i_br_upd.update && (i_br_upd.brtag == disp_pkg::brtag_t'(b))) begin
        w_mask_next[b] = 1'b0;
      end
      // younger branches die with a live mispredict
      if (i_br_upd.update && i_br_upd.mispredict && !i_br_upd.dead &&
          !i_br_upd.br_mask[b]) begin
        w_mask_next[b] = 1'b0;
      end
      w_free_cnt = w_free_cnt + disp_pkg::brcnt_t'(!w_mask_next[b]);
    end
  end

  // --------------------------------------------------
  // tag and mask chain through the slots
  // --------------------------------------------------
  always_comb begin
    w_tag_chain[0]  = r_tag_ptr;
    w_mask_chain[0] = w_mask_next;
    w_br_cnt        = '0;
    for (int d = 0; d < disp_pkg::DISP_SIZE; d++) begin
      w_is_br[d] = i_group.inst[d].valid && (i_group.inst[d].cat == disp_pkg::BR);

      o_group.inst[d].inst   = i_group.inst[d];
      o_group.inst[d].brtag  = w_tag_chain[d];
      o_group.inst[d].brmask = w_mask_chain[d];

      if (w_is_br[d]) begin
        w_tag_chain[d+1]  = w_tag_chain[d] + disp_pkg::brtag_t'(1);
        w_mask_chain[d+1] = w_mask_chain[d] | (disp_pkg::brmask_t'(1) << w_tag_chain[d]);
        w_br_cnt          = w_br_cnt + disp_pkg::brcnt_t'(1);
      end else begin
        w_tag_chain[d+1]  = w_tag_chain[d];
        w_mask_chain[d+1] = w_mask_chain[d];
      end
    end
  end

  assign o_tag_ok = (w_br_cnt <= w_free_cnt);

  // --------------------------------------------------
  // pointer and live mask
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tag_ptr    <= '0;
      r_mask_valid <= '0;
    end else if (i_commit_flush) begin
      // pointer keeps counting across a flush
      r_mask_valid <= '0;
    end else if (i_alloc) begin
      r_tag_ptr    <= w_tag_chain[disp_pkg::DISP_SIZE];
      r_mask_valid <= w_mask_chain[disp_pkg::DISP_SIZE];
    end else begin
      r_mask_valid <= w_mask_next;
    end
  end

endmodule

// File: hdl/credit_counter.sv
// --------------------------------------------------
// free entry count of one backend structure
// caller must never consume more than o_credits
// returns beyond MAX_CREDITS are not clipped
// --------------------------------------------------

module credit_counter #(
  parameter int unsigned MAX_CREDITS = 4
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  input  logic                   i_consume,
  input  disp_pkg::credit_t      i_consume_cnt,
  input  disp_pkg::credit_ret_t  i_ret,

  output disp_pkg::credit_t      o_credits
);

  disp_pkg::credit_t r_credits;
  disp_pkg::credit_t w_sub;
  disp_pkg::credit_t w_add;
  disp_pkg::credit_t w_credits_next;

  // --------------------------------------------------
  // per-cycle update
  // --------------------------------------------------
  always_comb begin
    w_sub = '0;
    w_add = '0;
    if (i_consume) begin
      w_sub = i_consume_cnt;
    end
    // returned entries join the count at the edge, usable next cycle
    if (i_ret.valid) begin
      w_add = i_ret.cnt;
    end
    w_credits_next = r_credits - w_sub + w_add;
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_credits <= disp_pkg::credit_t'(MAX_CREDITS);
    end else begin
      r_credits <= w_credits_next;
    end
  end

  assign o_credits = r_credits;

endmodule

// File: hdl/disp_group_buf.sv
// --------------------------------------------------
// one-entry input buffer for a decoded group
// no transfer is accepted in a flush cycle
// --------------------------------------------------

module disp_group_buf (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic                  i_valid,
  input  disp_pkg::disp_group_t i_group,
  output logic                  o_ready,

  input  logic                  i_take,
  input  logic                  i_flush,

  output logic                  o_valid,
  output disp_pkg::disp_group_t o_group
);

  logic                  r_valid;
  disp_pkg::disp_group_t r_group;

  // room when empty or when the held group leaves this cycle
  assign o_ready = ~i_flush & (~r_valid | i_take);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (i_flush) begin
      r_valid <= 1'b0;
    end else if (o_ready) begin
      r_valid <= i_valid;
    end
  end

  // payload
  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      r_group <= i_group;
    end
  end

  assign o_valid = r_valid;
  assign o_group = r_group;

endmodule

// File: hdl/disp_out_stage.sv
// --------------------------------------------------
// output register for the tagged group
// i_load is only raised while o_free is high
// --------------------------------------------------

module disp_out_stage (
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  input  logic                    i_load,
  input  disp_pkg::tagged_group_t i_group,
  input  logic                    i_flush,
  output logic                    o_free,

  output logic                    o_valid,
  output disp_pkg::tagged_group_t o_group,
  input  logic                    i_ready
);

  logic                    r_valid;
  disp_pkg::tagged_group_t r_group;

  // empty, or the held group is read this cycle
  assign o_free = ~r_valid | i_ready;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (i_flush) begin
      r_valid <= 1'b0;
    end else if (i_load) begin
      r_valid <= 1'b1;
    end else if (i_ready) begin
      r_valid <= 1'b0;
    end
  end

  // held stable under back-pressure
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_group <= i_group;
    end
  end

  assign o_valid = r_valid;
  assign o_group = r_group;

endmodule

// File: hdl/disp_pkg.sv
// --------------------------------------------------
// shared widths, depths and types of the dispatch stage
// BR_TAG_NUM must be a power of two, tags wrap modulo
// CREDIT_W must hold the largest credit depth
// --------------------------------------------------

package disp_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int unsigned DISP_SIZE  = 2;
  localparam int unsigned BR_TAG_NUM = 4;

  localparam int unsigned ROB_SIZE   = 8;
  localparam int unsigned ALU_Q_SIZE = 4;
  localparam int unsigned LDQ_SIZE   = 4;
  localparam int unsigned STQ_SIZE   = 4;
  localparam int unsigned BRQ_SIZE   = 4;

  localparam int unsigned CREDIT_W   = 4;
  localparam int unsigned Q_NUM      = 5;

  // depth of each credit port, in q_sel_e order
  localparam int unsigned Q_DEPTH [Q_NUM] = '{ROB_SIZE, ALU_Q_SIZE, LDQ_SIZE, STQ_SIZE, BRQ_SIZE};

  // --------------------------------------------------
  // vector types
  // --------------------------------------------------
  typedef logic [CREDIT_W-1:0]             credit_t;
  typedef logic [$clog2(BR_TAG_NUM)-1:0]   brtag_t;
  typedef logic [BR_TAG_NUM-1:0]           brmask_t;
  typedef logic [$clog2(BR_TAG_NUM):0]     brcnt_t;
  typedef logic [15:0]                     inst_word_t;

  typedef enum logic [2:0] {
    NONE = 3'd0,
    ALU  = 3'd1,
    LD   = 3'd2,
    ST   = 3'd3,
    BR   = 3'd4
  } inst_cat_e;

  // credit port select, also the index of the return array
  typedef enum logic [2:0] {
    Q_ROB = 3'd0,
    Q_ALU = 3'd1,
    Q_LDQ = 3'd2,
    Q_STQ = 3'd3,
    Q_BRQ = 3'd4
  } q_sel_e;

  // --------------------------------------------------
  // bundles
  // --------------------------------------------------
  typedef struct packed {
    logic       valid;
    inst_cat_e  cat;
    inst_word_t word;
  } disp_inst_t;

  typedef struct packed {
    disp_inst_t [DISP_SIZE-1:0] inst;
  } disp_group_t;

  typedef struct packed {
    disp_inst_t inst;
    brtag_t     brtag;
    brmask_t    brmask;
  } tagged_inst_t;

  typedef struct packed {
    tagged_inst_t [DISP_SIZE-1:0] inst;
  } tagged_group_t;

  typedef struct packed {
    logic    valid;
    credit_t cnt;
  } credit_ret_t;

  typedef struct packed {
    logic    update;
    logic    mispredict;
    logic    dead;
    brtag_t  brtag;
    brmask_t br_mask;
  } br_upd_t;

endpackage

// File: hdl/disp_top.sv
// --------------------------------------------------
// dispatch resource allocation stage
// two cycles from input to output without a stall
// --------------------------------------------------

module disp_top (
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  input  logic                    i_in_valid,
  input  disp_pkg::disp_group_t   i_in_group,
  output logic                    o_in_ready,

  output logic                    o_out_valid,
  output disp_pkg::tagged_group_t o_out_group,
  input  logic                    i_out_ready,

  input  disp_pkg::credit_ret_t [disp_pkg::Q_NUM-1:0] i_credit_ret,
  input  disp_pkg::br_upd_t       i_br_upd,
  input  logic                    i_commit_flush
);

  logic                    w_buf_valid;
  disp_pkg::disp_group_t   w_buf_group;
  logic                    w_take;
  logic                    w_flush;
  logic                    w_out_free;
  disp_pkg::tagged_group_t w_alloc_group;

  disp_group_buf u_group_buf (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_in_valid),
    .i_group   (i_in_group),
    .o_ready   (o_in_ready),
    .i_take    (w_take),
    .i_flush   (w_flush),
    .o_valid   (w_buf_valid),
    .o_group   (w_buf_group)
  );

  resource_alloc u_resource_alloc (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_valid        (w_buf_valid),
    .i_group        (w_buf_group),
    .i_out_free     (w_out_free),
    .i_credit_ret   (i_credit_ret),
    .i_br_upd       (i_br_upd),
    .i_commit_flush (i_commit_flush),
    .o_take         (w_take),
    .o_flush        (w_flush),
    .o_group        (w_alloc_group)
  );

  disp_out_stage u_out_stage (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_load    (w_take),
    .i_group   (w_alloc_group),
    .i_flush   (w_flush),
    .o_free    (w_out_free),
    .o_valid   (o_out_valid),
    .o_group   (o_out_group),
    .i_ready   (i_out_ready)
  );

endmodule

// File: hdl/resource_alloc.sv
// --------------------------------------------------
// backend credit check and dispatch decision
// a group fires only if every structure can take it whole
// no credits or tags are taken while a flush is active
// --------------------------------------------------

module resource_alloc (
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  input  logic                    i_valid,
  input  disp_pkg::disp_group_t   i_group,
  input  logic                    i_out_free,

  input  disp_pkg::credit_ret_t [disp_pkg::Q_NUM-1:0] i_credit_ret,
  input  disp_pkg::br_upd_t       i_br_upd,
  input  logic                    i_commit_flush,

  output logic                    o_take,
  output logic                    o_flush,
  output disp_pkg::tagged_group_t o_group
);

  disp_pkg::credit_t [disp_pkg::Q_NUM-1:0] w_demand;
  disp_pkg::credit_t [disp_pkg::Q_NUM-1:0] w_credits;
  logic              [disp_pkg::Q_NUM-1:0] w_credit_ok;

  logic w_br_flush;
  logic w_tag_ok;
  logic w_fire;

  // --------------------------------------------------
  // flush sources
  // --------------------------------------------------
  assign w_br_flush = i_br_upd.update & i_br_upd.mispredict & ~i_br_upd.dead;
  assign o_flush    = i_commit_flush | w_br_flush;

  // --------------------------------------------------
  // demand of the buffered group
  // --------------------------------------------------
  always_comb begin
    w_demand = '0;
    for (int d = 0; d < disp_pkg::DISP_SIZE; d++) begin
      if (i_group.inst[d].valid) begin
        // one rob entry covers the whole group
        w_demand[disp_pkg::Q_ROB] = disp_pkg::credit_t'(1);
        case (i_group.inst[d].cat)
          disp_pkg::ALU: w_demand[disp_pkg::Q_ALU] = w_demand[disp_pkg::Q_ALU] + 1'b1;
          disp_pkg::LD:  w_demand[disp_pkg::Q_LDQ] = w_demand[disp_pkg::Q_LDQ] + 1'b1;
          disp_pkg::ST:  w_demand[disp_pkg::Q_STQ] = w_demand[disp_pkg::Q_STQ] + 1'b1;
          disp_pkg::BR:  w_demand[disp_pkg::Q_BRQ] = w_demand[disp_pkg::Q_BRQ] + 1'b1;
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------
  // credit counters, one per backend structure
  // --------------------------------------------------
  for (genvar q = 0; q < disp_pkg::Q_NUM; q++) begin : g_credit
    credit_counter #(
      .MAX_CREDITS (disp_pkg::Q_DEPTH[q])
    ) u_credit (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_consume     (w_fire),
      .i_consume_cnt (w_demand[q]),
      .i_ret         (i_credit_ret[q]),
      .o_credits     (w_credits[q])
    );

    assign w_credit_ok[q] = (w_demand[q] <= w_credits[q]);
  end

  // --------------------------------------------------
  // branch tags
  // --------------------------------------------------
  brtag_alloc u_brtag (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_group        (i_group),
    .i_alloc        (w_fire),
    .i_br_upd       (i_br_upd),
    .i_commit_flush (i_commit_flush),
    .o_tag_ok       (w_tag_ok),
    .o_group        (o_group)
  );

  // dispatch decision
  assign w_fire = i_valid & i_out_free & (&w_credit_ok) & w_tag_ok & ~o_flush;
  assign o_take = w_fire;

endmodule

// File: verification/disp_asserts.sv
// --------------------------------------------------
// bound checks for credit counters and output stage
// tie unused inputs off at the bind site
// --------------------------------------------------

module disp_asserts #(
  parameter int unsigned MAX_CREDITS = 15
) (
  input logic                    i_clk,
  input logic                    i_reset_n,
  input disp_pkg::credit_t       i_credits,
  input logic                    i_valid,
  input logic                    i_ready,
  input logic                    i_flush,
  input disp_pkg::tagged_group_t i_group
);

  // free credits stay within the structure depth
  a_credit_bound: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_credits <= MAX_CREDITS)
    else $error("credit count above its depth");

  // held group must not move under back-pressure
  a_out_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_valid && !i_ready && !i_flush) |=> (i_valid && $stable(i_group)))
    else $error("held output group changed");

  a_out_reset: assert property (@(posedge i_clk) !i_reset_n |=> !i_valid)
    else $error("output valid after reset");

endmodule

// File: verification/disp_input.txt
# cmd a0 a1 a2 a3 in hex, G cat0 word0 cat1 word1, R port cnt, U tag misp dead mask
# F fired_groups, P ready_mode(0 on 1 random 2 off), S cycles, E tag0 mask0 tag1 mask1
G 4 1111 1 2222
E 0 0 1 1
G 1 3333 4 4444
E 1 1 1 1
G 1 5555 1 6666
E 2 3 2 3
G 1 7777 2 8888
S 5 0 0 0
R 1 1 0 0
E 2 3 2 3
R 1 4 0 0
R 0 4 0 0
G 2 9999 2 aaaa
E 2 3 2 3
G 2 bbbb 2 cccc
S 4 0 0 0
R 2 3 0 0
E 2 3 2 3
R 2 2 0 0
R 0 2 0 0
R 4 2 0 0
P 1 0 0 0
G 3 0101 1 0202
G 1 0303 0 0000
G 3 0404 3 0505
G 0 0000 1 0606
E 2 3 2 3
E 2 3 2 3
E 2 3 2 3
E 2 3 2 3
P 0 0 0 0
R 0 4 0 0
R 1 3 0 0
R 3 3 0 0
G 4 0d0d 4 0e0e
E 2 3 3 7
G 4 0f0f 0 0000
S 4 0 0 0
U 0 0 0 0
E 0 e 0 0
U 1 1 0 1
R 4 3 0 0
G 4 1010 4 1111
E 1 1 2 3
P 2 0 0 0
G 1 1212 4 1313
G 1 1414 0 0000
F 1 0 0 0
P 0 0 0 0
R 4 3 0 0
G 4 1515 0 0000
E 0 0 0 0
G 4 1616 0 0000
E 1 1 0 0

// File: verification/disp_tb.sv
// --------------------------------------------------
// file-driven testbench for the dispatch stage
// run from the project root, stimulus path is relative
// E and S lines must follow the groups they refer to
// --------------------------------------------------

module disp_tb;

  localparam string INPUT_FILE = "verification/disp_input.txt";

  logic clk;
  logic reset_n;
  logic in_valid;
  logic in_ready;
  logic out_valid;
  logic out_ready;
  logic commit_flush;
  disp_pkg::disp_group_t                     in_group;
  disp_pkg::tagged_group_t                   out_group;
  disp_pkg::credit_ret_t [disp_pkg::Q_NUM-1:0] credit_ret;
  disp_pkg::br_upd_t                         br_upd;

  integer seed = 32'hf66b_562c;
  int     bp_mode = 0;
  int     wd_cycles = 0;

  // reference model state
  disp_pkg::disp_group_t   pending [$];
  disp_pkg::tagged_group_t observed [$];
  int                      m_cred [disp_pkg::Q_NUM];
  disp_pkg::brtag_t        m_ptr;
  disp_pkg::brmask_t       m_mask;

  byte         cmd_q [$];
  logic [31:0] a0_q [$];
  logic [31:0] a1_q [$];
  logic [31:0] a2_q [$];
  logic [31:0] a3_q [$];

  disp_top u_dut (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_in_valid     (in_valid),
    .i_in_group     (in_group),
    .o_in_ready     (in_ready),
    .o_out_valid    (out_valid),
    .o_out_group    (out_group),
    .i_out_ready    (out_ready),
    .i_credit_ret   (credit_ret),
    .i_br_upd       (br_upd),
    .i_commit_flush (commit_flush)
  );

  bind credit_counter disp_asserts #(.MAX_CREDITS(MAX_CREDITS)) u_credit_asserts (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_credits(o_credits),
    .i_valid(1'b0), .i_ready(1'b1), .i_flush(1'b0), .i_group('0)
  );

  bind disp_out_stage disp_asserts u_out_asserts (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_credits('0),
    .i_valid(o_valid), .i_ready(i_ready), .i_flush(i_flush), .i_group(o_group)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // failure reporting and typed compares
  // --------------------------------------------------
  task automatic report_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic compare_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic compare_tag(input string name, input disp_pkg::brtag_t got,
                             input disp_pkg::brtag_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  task automatic compare_mask(input string name, input disp_pkg::brmask_t got,
                              input disp_pkg::brmask_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic compare_cat(input string name, input disp_pkg::inst_cat_e got,
                             input disp_pkg::inst_cat_e exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail at %0t: %s is %s, expected %s", $time, name,
                               got.name(), exp.name()));
    end
  endtask

  task automatic compare_word(input string name, input disp_pkg::inst_word_t got,
                              input disp_pkg::inst_word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic void group_demand(input disp_pkg::disp_group_t g,
                                       output int dem [disp_pkg::Q_NUM]);
    foreach (dem[q]) dem[q] = 0;
    for (int d = 0; d < disp_pkg::DISP_SIZE; d++) begin
      if (g.inst[d].valid) begin
        dem[disp_pkg::Q_ROB] = 1;
        case (g.inst[d].cat)
          disp_pkg::ALU: dem[disp_pkg::Q_ALU]++;
          disp_pkg::LD:  dem[disp_pkg::Q_LDQ]++;
          disp_pkg::ST:  dem[disp_pkg::Q_STQ]++;
          disp_pkg::BR:  dem[disp_pkg::Q_BRQ]++;
          default: ;
        endcase
      end
    end
  endfunction

  function automatic bit can_dispatch(input disp_pkg::disp_group_t g);
    int dem [disp_pkg::Q_NUM];
    int free_tags;
    bit ok;
    group_demand(g, dem);
    free_tags = 0;
    ok = 1'b1;
    for (int b = 0; b < disp_pkg::BR_TAG_NUM; b++) begin
      if (!m_mask[b]) free_tags++;
    end
    for (int q = 0; q < disp_pkg::Q_NUM; q++) begin
      if (dem[q] > m_cred[q]) ok = 1'b0;
    end
    // every branch slot needs its own tag
    if (dem[disp_pkg::Q_BRQ] > free_tags) ok = 1'b0;
    return ok;
  endfunction

  function automatic disp_pkg::tagged_group_t dispatch_ref(input disp_pkg::disp_group_t g);
    int dem [disp_pkg::Q_NUM];
    disp_pkg::tagged_group_t t;
    disp_pkg::brtag_t        tag;
    disp_pkg::brmask_t       msk;
    group_demand(g, dem);
    for (int q = 0; q < disp_pkg::Q_NUM; q++) m_cred[q] -= dem[q];
    tag = m_ptr;
    msk = m_mask;
    for (int d = 0; d < disp_pkg::DISP_SIZE; d++) begin
      t.inst[d].inst   = g.inst[d];
      t.inst[d].brtag  = tag;
      t.inst[d].brmask = msk;
      if (g.inst[d].valid && g.inst[d].cat == disp_pkg::BR) begin
        msk = msk | (disp_pkg::brmask_t'(1) << tag);
        tag = tag + disp_pkg::brtag_t'(1);
      end
    end
    m_ptr  = tag;
    m_mask = msk;
    return t;
  endfunction

  // --------------------------------------------------
  // commands
  // --------------------------------------------------
  task automatic send_group(input logic [31:0] c0, input logic [31:0] w0,
                            input logic [31:0] c1, input logic [31:0] w1);
    disp_pkg::disp_group_t g;
    g.inst[0].valid = (c0[2:0] != 3'd0);
    g.inst[0].cat   = disp_pkg::inst_cat_e'(c0[2:0]);
    g.inst[0].word  = w0[15:0];
    g.inst[1].valid = (c1[2:0] != 3'd0);
    g.inst[1].cat   = disp_pkg::inst_cat_e'(c1[2:0]);
    g.inst[1].word  = w1[15:0];
    @(negedge clk);
    in_valid = 1'b1;
    in_group = g;
    #1;
    while (!in_ready) begin
      @(negedge clk);
      #1;
    end
    pending.push_back(g);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic return_credit(input logic [31:0] q, input logic [31:0] cnt);
    @(negedge clk);
    credit_ret[q].valid = 1'b1;
    credit_ret[q].cnt   = disp_pkg::credit_t'(cnt);
    m_cred[q] += int'(cnt);
    @(negedge clk);
    credit_ret = '0;
  endtask

  task automatic branch_update(input logic [31:0] tag, input logic [31:0] misp,
                               input logic [31:0] dead, input logic [31:0] mask);
    @(negedge clk);
    br_upd.update     = 1'b1;
    br_upd.mispredict = misp[0];
    br_upd.dead       = dead[0];
    br_upd.brtag      = disp_pkg::brtag_t'(tag);
    br_upd.br_mask    = disp_pkg::brmask_t'(mask);
    m_mask = m_mask & ~(disp_pkg::brmask_t'(1) << tag[1:0]);
    // live mispredict squashes younger tags and anything in flight
    if (misp[0] && !dead[0]) begin
      m_mask = m_mask & disp_pkg::brmask_t'(mask);
      pending.delete();
    end
    @(negedge clk);
    br_upd = '0;
  endtask

  task automatic apply_flush(input logic [31:0] fired);
    repeat (fired) begin
      if (pending.size() == 0) report_failure("flush line names more groups than were sent");
      void'(dispatch_ref(pending.pop_front()));
    end
    pending.delete();
    m_mask = '0;
    @(negedge clk);
    commit_flush = 1'b1;
    @(negedge clk);
    commit_flush = 1'b0;
  endtask

  task automatic expect_stall(input logic [31:0] cycles);
    if (pending.size() == 0 || can_dispatch(pending[0])) begin
      report_failure("stall expected but the reference model predicts a dispatch");
    end
    repeat (cycles) begin
      @(negedge clk);
      #1;
      if (out_valid) report_failure("a group was dispatched during an expected stall");
    end
  endtask

  task automatic expect_group(input logic [31:0] t0, input logic [31:0] m0,
                              input logic [31:0] t1, input logic [31:0] m1);
    disp_pkg::disp_group_t   g;
    disp_pkg::tagged_group_t got;
    disp_pkg::tagged_group_t exp;
    logic [31:0]             ftag [2];
    logic [31:0]             fmask [2];
    ftag[0]  = t0;
    ftag[1]  = t1;
    fmask[0] = m0;
    fmask[1] = m1;
    while (observed.size() == 0) @(negedge clk);
    got = observed.pop_front();
    if (pending.size() == 0) report_failure("the DUT sent a group that was never accepted");
    g   = pending.pop_front();
    exp = dispatch_ref(g);
    for (int d = 0; d < disp_pkg::DISP_SIZE; d++) begin
      if (g.inst[d].valid && (exp.inst[d].brtag != disp_pkg::brtag_t'(ftag[d]) ||
                              exp.inst[d].brmask != disp_pkg::brmask_t'(fmask[d]))) begin
        report_failure("stimulus file expectation disagrees with the reference model");
      end
      compare_valid($sformatf("o_out_group.inst[%0d].valid", d),
                    got.inst[d].inst.valid, exp.inst[d].inst.valid);
      compare_cat($sformatf("o_out_group.inst[%0d].cat", d),
                  got.inst[d].inst.cat, exp.inst[d].inst.cat);
      compare_word($sformatf("o_out_group.inst[%0d].word", d),
                   got.inst[d].inst.word, exp.inst[d].inst.word);
      compare_tag($sformatf("o_out_group.inst[%0d].brtag", d),
                  got.inst[d].brtag, exp.inst[d].brtag);
      compare_mask($sformatf("o_out_group.inst[%0d].brmask", d),
                   got.inst[d].brmask, exp.inst[d].brmask);
    end
  endtask

  // --------------------------------------------------
  // output ready and transfer capture
  // --------------------------------------------------
  initial begin
    forever begin
      @(negedge clk);
      if (bp_mode == 1) out_ready = 1'($random(seed) & 1);
      else out_ready = (bp_mode == 0);
      #1;
      if (reset_n && out_valid && out_ready) observed.push_back(out_group);
    end
  end

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    report_failure("timeout, the run did not finish in time");
  end

  initial begin
    int          fd;
    int          n;
    string       line;
    byte         c;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;
    reset_n      = 1'b0;
    in_valid     = 1'b0;
    in_group     = '0;
    out_ready    = 1'b1;
    credit_ret   = '0;
    br_upd       = '0;
    commit_flush = 1'b0;
    for (int q = 0; q < disp_pkg::Q_NUM; q++) m_cred[q] = disp_pkg::Q_DEPTH[q];
    m_ptr  = '0;
    m_mask = '0;

    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) report_failure("cannot open the stimulus file");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line, "%c %h %h %h %h", c, a0, a1, a2, a3);
        if (n != 5) report_failure("malformed line in the stimulus file");
        cmd_q.push_back(c);
        a0_q.push_back(a0);
        a1_q.push_back(a1);
        a2_q.push_back(a2);
        a3_q.push_back(a3);
      end
    end
    $fclose(fd);
    wd_cycles = cmd_q.size() * 50;

    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    foreach (cmd_q[i]) begin
      case (cmd_q[i])
        "G": send_group(a0_q[i], a1_q[i], a2_q[i], a3_q[i]);
        "R": return_credit(a0_q[i], a1_q[i]);
        "U": branch_update(a0_q[i], a1_q[i], a2_q[i], a3_q[i]);
        "F": apply_flush(a0_q[i]);
        "P": bp_mode = int'(a0_q[i]);
        "S": expect_stall(a0_q[i]);
        "E": expect_group(a0_q[i], a1_q[i], a2_q[i], a3_q[i]);
        default: report_failure("unknown command in the stimulus file");
      endcase
    end

    repeat (4) @(negedge clk);
    if (observed.size() != 0 || pending.size() != 0) begin
      report_failure("groups left over at the end of the run");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule
